/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu_ctrl
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/control_word_gen.sv */
`default_nettype none
`include "cpu_ctrl_defs.svh"

module control_word_gen (
  input  cpu_ctrl_pkg::state_e         state,
  input  cpu_ctrl_pkg::decoded_instr_t dec,
  output cpu_ctrl_pkg::ctrl_word_t     ctrl
);

  import cpu_ctrl_pkg::*;

  reg_sel_e store_src;

  // Store register, or T for a read-modify-write
  assign store_src = dec.is_store ? dec.mov_src : REG_T;

  always_comb begin
    // Idle word
    ctrl.bus.r_w        = `RW_READ;
    ctrl.bus.db_out_src = REG_A;
    ctrl.bus.dl_we      = 1'b0;
    ctrl.bus.ir_we      = 1'b0;

    ctrl.pc.pc_adder = PC_ADD_NOP;
    ctrl.pc.pcl_src  = PCL_SRC_MEM;
    ctrl.pc.pch_src  = PCH_SRC_MEM;
    ctrl.pc.pcl_we   = 1'b0;
    ctrl.pc.pch_we   = 1'b0;

    ctrl.regs.reg_src = REG_MEM;
    ctrl.regs.a_we    = 1'b0;
    ctrl.regs.x_we    = 1'b0;
    ctrl.regs.y_we    = 1'b0;
    ctrl.regs.t_we    = 1'b0;

    ctrl.alu.alu_op = ALU_THA;
    ctrl.alu.src_a  = REG_A;
    ctrl.alu.src_b  = REG_T;

    ctrl.p.p_src  = P_SRC_NON;
    ctrl.p.p_mask = '0;

    ctrl.ab.abl_src = ABL_SRC_PC;
    ctrl.ab.abh_src = ABH_SRC_PC;
    ctrl.ab.abl_we  = 1'b0;
    ctrl.ab.abh_we  = 1'b0;

    case (state)
      T0_FETCH: begin
        ctrl.bus.ir_we   = 1'b1;
        ctrl.pc.pc_adder = PC_ADD_INC;
        ctrl.pc.pcl_src  = PCL_SRC_ADD;
        ctrl.pc.pch_src  = PCH_SRC_ADD;
        ctrl.pc.pcl_we   = 1'b1;
        ctrl.pc.pch_we   = 1'b1;
        ctrl.ab.abl_we   = 1'b1;
        ctrl.ab.abh_we   = 1'b1;

        // Overlap, the previous instruction retires here
        if (!dec.is_rmw) begin
          ctrl.regs.reg_src = (dec.is_load || dec.is_xfer) ? dec.mov_src : REG_ALU;
          ctrl.regs.a_we    = dec.mov_dst == REG_A;
          ctrl.regs.x_we    = dec.mov_dst == REG_X;
          ctrl.regs.y_we    = dec.mov_dst == REG_Y;
          ctrl.alu.alu_op   = dec.alu_op;
          ctrl.alu.src_a    = dec.alu_src_a;
          ctrl.p.p_src      = dec.p_src;
          ctrl.p.p_mask     = dec.flag_mask;
        end
      end
      T1_OPER: begin
        // Single byte instructions leave the PC alone
        if (dec.mode inside {MODE_IMP, MODE_ACC}) begin
          ctrl.pc.pc_adder = PC_ADD_NOP;
        end else begin
          ctrl.pc.pc_adder = PC_ADD_INC;
        end
        ctrl.pc.pcl_src   = PCL_SRC_ADD;
        ctrl.pc.pch_src   = PCH_SRC_ADD;
        ctrl.pc.pcl_we    = 1'b1;
        ctrl.pc.pch_we    = 1'b1;
        ctrl.bus.dl_we    = 1'b1;
        ctrl.regs.t_we    = 1'b1;
        ctrl.regs.reg_src = REG_MEM;
        ctrl.ab.abl_we    = 1'b1;
        ctrl.ab.abh_we    = 1'b1;
        if (dec.mode == MODE_ZPG) begin
          ctrl.ab.abl_src = ABL_SRC_MEM;
          ctrl.ab.abh_src = ABH_SRC_ZERO;
        end
      end
      T2_ABS: begin
        // High address byte arrives on the bus
        ctrl.bus.dl_we = 1'b1;
        if (dec.op == OP_JMP) begin
          ctrl.pc.pcl_src = PCL_SRC_T;
          ctrl.pc.pch_src = PCH_SRC_MEM;
        end else begin
          ctrl.pc.pc_adder = PC_ADD_INC;
          ctrl.pc.pcl_src  = PCL_SRC_ADD;
          ctrl.pc.pch_src  = PCH_SRC_ADD;
        end
        ctrl.pc.pcl_we  = 1'b1;
        ctrl.pc.pch_we  = 1'b1;
        ctrl.ab.abl_src = ABL_SRC_T;
        ctrl.ab.abh_src = ABH_SRC_MEM;
        ctrl.ab.abl_we  = 1'b1;
        ctrl.ab.abh_we  = 1'b1;
      end
      TX_RDATA: begin
        ctrl.bus.dl_we    = 1'b1;
        ctrl.regs.t_we    = 1'b1;
        ctrl.regs.reg_src = REG_MEM;
        // Keep the operand address for the write back
        if (!dec.is_rmw) begin
          ctrl.ab.abl_we = 1'b1;
          ctrl.ab.abh_we = 1'b1;
        end
      end
      TX_MDATA: begin
        // Old value goes back out while the ALU works on T
        ctrl.bus.r_w        = `RW_WRITE;
        ctrl.bus.db_out_src = REG_T;
        ctrl.alu.alu_op     = dec.alu_op;
        ctrl.alu.src_a      = dec.alu_src_a;
        ctrl.regs.t_we      = 1'b1;
        ctrl.regs.reg_src   = REG_ALU;
        ctrl.p.p_src        = dec.p_src;
        ctrl.p.p_mask       = dec.flag_mask;
      end
      TX_WDATA: begin
        ctrl.bus.r_w        = `RW_WRITE;
        ctrl.bus.db_out_src = store_src;
        ctrl.ab.abl_we      = 1'b1;
        ctrl.ab.abh_we      = 1'b1;
      end
      default: ;
    endcase

    // Register file has a single write port
    assert ($onehot0({ctrl.regs.a_we, ctrl.regs.x_we, ctrl.regs.y_we}));
  end

endmodule

`default_nettype wire

/* hw/cpu_ctrl_defs.svh */
`ifndef CPU_CTRL_DEFS_SVH
`define CPU_CTRL_DEFS_SVH

`define DATA_W     8
`define STATE_CNT  6

// R/W pin levels as on the 6502 bus
`define RW_READ    1'b1
`define RW_WRITE   1'b0

// Status register bits
`define FLAG_C     8'h01
`define FLAG_Z     8'h02
`define FLAG_N     8'h80

// Loads and stores
`define OPC_LDA_IMM 8'hA9
`define OPC_LDA_ZPG 8'hA5
`define OPC_LDA_ABS 8'hAD
`define OPC_LDX_IMM 8'hA2
`define OPC_LDY_IMM 8'hA0
`define OPC_STA_ZPG 8'h85
`define OPC_STA_ABS 8'h8D
`define OPC_STX_ZPG 8'h86
`define OPC_STY_ABS 8'h8C

// ALU group
`define OPC_ADC_IMM 8'h69
`define OPC_SBC_IMM 8'hE9
`define OPC_AND_ZPG 8'h25
`define OPC_ORA_IMM 8'h09
`define OPC_EOR_ABS 8'h4D
`define OPC_CMP_IMM 8'hC9

// Shifts and increments
`define OPC_ASL_ACC 8'h0A
`define OPC_LSR_ACC 8'h4A
`define OPC_ROL_ZPG 8'h26
`define OPC_ROR_ABS 8'h6E
`define OPC_INC_ZPG 8'hE6
`define OPC_DEC_ABS 8'hCE

// Single byte and jump
`define OPC_INX     8'hE8
`define OPC_DEX     8'hCA
`define OPC_TAX     8'hAA
`define OPC_TAY     8'hA8
`define OPC_TXA     8'h8A
`define OPC_TYA     8'h98
`define OPC_CLC     8'h18
`define OPC_SEC     8'h38
`define OPC_JMP_ABS 8'h4C
`define OPC_NOP     8'hEA

`endif

/* hw/cpu_ctrl_pkg.sv */
`default_nettype none
`include "cpu_ctrl_defs.svh"

package cpu_ctrl_pkg;

  typedef enum logic [4:0] {
    OP_NOP, OP_LDA, OP_LDX, OP_LDY, OP_STA, OP_STX, OP_STY,
    OP_ADC, OP_SBC, OP_AND, OP_ORA, OP_EOR, OP_CMP,
    OP_ASL, OP_LSR, OP_ROL, OP_ROR, OP_INC, OP_DEC,
    OP_INX, OP_DEX, OP_TAX, OP_TAY, OP_TXA, OP_TYA,
    OP_CLC, OP_SEC, OP_JMP
  } op_e;

  typedef enum logic [2:0] {
    MODE_IMP, MODE_ACC, MODE_IMM, MODE_ZPG, MODE_ABS
  } addr_mode_e;

  typedef enum logic [$clog2(`STATE_CNT)-1:0] {
    T0_FETCH, T1_OPER, T2_ABS, TX_RDATA, TX_MDATA, TX_WDATA
  } state_e;

  // Register file ports and internal buses
  typedef enum logic [2:0] {
    REG_A, REG_X, REG_Y, REG_T, REG_MEM, REG_ALU
  } reg_sel_e;

  // THA passes operand A straight through
  typedef enum logic [3:0] {
    ALU_THA, ALU_ADC, ALU_SBC, ALU_AND, ALU_ORA, ALU_EOR, ALU_CMP,
    ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR, ALU_INC, ALU_DEC
  } alu_op_e;

  typedef enum logic {PC_ADD_NOP, PC_ADD_INC} pc_adder_e;
  typedef enum logic [1:0] {PCL_SRC_MEM, PCL_SRC_T, PCL_SRC_ADD} pcl_src_e;
  typedef enum logic {PCH_SRC_MEM, PCH_SRC_ADD} pch_src_e;
  typedef enum logic [1:0] {P_SRC_NON, P_SRC_ALU, P_SRC_SET, P_SRC_CLR} p_src_e;
  typedef enum logic [1:0] {ABL_SRC_PC, ABL_SRC_MEM, ABL_SRC_T} abl_src_e;
  typedef enum logic [1:0] {ABH_SRC_PC, ABH_SRC_MEM, ABH_SRC_ZERO} abh_src_e;

  typedef struct packed {
    op_e        op;
    addr_mode_e mode;
    logic       is_load;
    logic       is_store;
    logic       is_rmw;
    logic       is_xfer;
    reg_sel_e   mov_src;
    reg_sel_e   mov_dst;
    alu_op_e    alu_op;
    reg_sel_e   alu_src_a;
    p_src_e     p_src;
    logic [7:0] flag_mask;
  } decoded_instr_t;

  typedef struct packed {
    logic     r_w;
    reg_sel_e db_out_src;
    logic     dl_we;
    logic     ir_we;
  } bus_ctrl_t;

  typedef struct packed {
    pc_adder_e pc_adder;
    pcl_src_e  pcl_src;
    pch_src_e  pch_src;
    logic      pcl_we;
    logic      pch_we;
  } pc_ctrl_t;

  typedef struct packed {
    reg_sel_e reg_src;
    logic     a_we;
    logic     x_we;
    logic     y_we;
    logic     t_we;
  } reg_ctrl_t;

  typedef struct packed {
    alu_op_e  alu_op;
    reg_sel_e src_a;
    reg_sel_e src_b;
  } alu_ctrl_t;

  typedef struct packed {
    p_src_e     p_src;
    logic [7:0] p_mask;
  } p_ctrl_t;

  typedef struct packed {
    abl_src_e abl_src;
    abh_src_e abh_src;
    logic     abl_we;
    logic     abh_we;
  } ab_ctrl_t;

  // One word per clock to the datapath
  typedef struct packed {
    bus_ctrl_t bus;
    pc_ctrl_t  pc;
    reg_ctrl_t regs;
    alu_ctrl_t alu;
    p_ctrl_t   p;
    ab_ctrl_t  ab;
  } ctrl_word_t;

endpackage

`default_nettype wire

/* hw/cpu_ctrl_top.sv */
`default_nettype none
`include "cpu_ctrl_defs.svh"

module cpu_ctrl_top (
  input  logic                     CLK,
  input  logic                     arst_n,
  input  logic                     rdy,
  input  logic [`DATA_W-1:0]       data_in,
  output cpu_ctrl_pkg::ctrl_word_t ctrl,
  output logic                     sync
);

  import cpu_ctrl_pkg::*;

  state_e         state;
  logic [`DATA_W-1:0] ir;
  decoded_instr_t dec;

  timing_sequencer timing_sequencer_inst (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .rdy     (rdy),
    .data_in (data_in),
    .dec     (dec),
    .state   (state),
    .ir      (ir)
  );

  opcode_decoder opcode_decoder_inst (
    .ir  (ir),
    .dec (dec)
  );

  control_word_gen control_word_gen_inst (
    .state (state),
    .dec   (dec),
    .ctrl  (ctrl)
  );

  // Opcode fetch cycle
  assign sync = (state == T0_FETCH);

endmodule

`default_nettype wire

/* hw/opcode_decoder.sv */
`default_nettype none
`include "cpu_ctrl_defs.svh"

module opcode_decoder (
  input  logic [`DATA_W-1:0]          ir,
  output cpu_ctrl_pkg::decoded_instr_t dec
);

  import cpu_ctrl_pkg::*;

  // Opcode layout aaabbbcc
  logic [2:0] aaa;
  logic [2:0] bbb;
  logic [1:0] cc;
  op_e        grp_op;
  addr_mode_e grp_mode;
  logic       grp_ok;
  op_e        op;
  addr_mode_e mode;

  assign aaa = ir[7:5];
  assign bbb = ir[4:2];
  assign cc  = ir[1:0];

  // Operation of the regular groups
  always_comb begin
    case ({cc, aaa})
      5'b01_000: grp_op = OP_ORA;
      5'b01_001: grp_op = OP_AND;
      5'b01_010: grp_op = OP_EOR;
      5'b01_011: grp_op = OP_ADC;
      5'b01_100: grp_op = OP_STA;
      5'b01_101: grp_op = OP_LDA;
      5'b01_110: grp_op = OP_CMP;
      5'b01_111: grp_op = OP_SBC;
      5'b10_000: grp_op = OP_ASL;
      5'b10_001: grp_op = OP_ROL;
      5'b10_010: grp_op = OP_LSR;
      5'b10_011: grp_op = OP_ROR;
      5'b10_100: grp_op = OP_STX;
      5'b10_101: grp_op = OP_LDX;
      5'b10_110: grp_op = OP_DEC;
      5'b10_111: grp_op = OP_INC;
      5'b00_100: grp_op = OP_STY;
      5'b00_101: grp_op = OP_LDY;
      default:   grp_op = OP_NOP;
    endcase
  end

  // Mode field, valid only where the group has that mode
  always_comb begin
    grp_mode = MODE_IMP;
    grp_ok   = 1'b0;
    case (bbb)
      3'b000: begin
        grp_mode = MODE_IMM;
        grp_ok   = (cc != 2'b01) && (aaa == 3'b101);
      end
      3'b001: begin
        grp_mode = MODE_ZPG;
        grp_ok   = 1'b1;
      end
      3'b010: begin
        grp_mode = (cc == 2'b01) ? MODE_IMM : MODE_ACC;
        grp_ok   = ((cc == 2'b01) && (aaa != 3'b100)) || ((cc == 2'b10) && !aaa[2]);
      end
      3'b011: begin
        grp_mode = MODE_ABS;
        grp_ok   = 1'b1;
      end
      default: grp_ok = 1'b0;
    endcase
    if (grp_op == OP_NOP) begin
      grp_ok = 1'b0;
    end
  end

  // Single byte opcodes sit in holes of the group map
  always_comb begin
    op   = grp_ok ? grp_op : OP_NOP;
    mode = grp_ok ? grp_mode : MODE_IMP;
    case (ir)
      `OPC_INX: op = OP_INX;
      `OPC_DEX: op = OP_DEX;
      `OPC_TAX: op = OP_TAX;
      `OPC_TAY: op = OP_TAY;
      `OPC_TXA: op = OP_TXA;
      `OPC_TYA: op = OP_TYA;
      `OPC_CLC: op = OP_CLC;
      `OPC_SEC: op = OP_SEC;
      `OPC_JMP_ABS: begin
        op   = OP_JMP;
        mode = MODE_ABS;
      end
      default: ;
    endcase
  end

  always_comb begin
    dec          = '0;
    dec.op       = op;
    dec.mode     = mode;
    dec.is_load  = op inside {OP_LDA, OP_LDX, OP_LDY};
    dec.is_store = op inside {OP_STA, OP_STX, OP_STY};
    dec.is_xfer  = op inside {OP_TAX, OP_TAY, OP_TXA, OP_TYA};
    dec.is_rmw   = (op inside {OP_ASL, OP_LSR, OP_ROL, OP_ROR, OP_INC, OP_DEC}) &&
                   (mode != MODE_ACC);

    // Source doubles as the store register
    case (op)
      OP_TAX, OP_TAY, OP_STA: dec.mov_src = REG_A;
      OP_TXA, OP_STX:         dec.mov_src = REG_X;
      OP_TYA, OP_STY:         dec.mov_src = REG_Y;
      default:                dec.mov_src = REG_T;
    endcase

    // T as destination means no write at T0
    case (op)
      OP_LDA, OP_TXA, OP_TYA, OP_ADC, OP_SBC, OP_AND, OP_ORA, OP_EOR:
        dec.mov_dst = REG_A;
      OP_LDX, OP_TAX, OP_INX, OP_DEX:
        dec.mov_dst = REG_X;
      OP_LDY, OP_TAY:
        dec.mov_dst = REG_Y;
      OP_ASL, OP_LSR, OP_ROL, OP_ROR:
        dec.mov_dst = (mode == MODE_ACC) ? REG_A : REG_T;
      default:
        dec.mov_dst = REG_T;
    endcase

    if (mode == MODE_ACC) begin
      dec.alu_src_a = REG_A;
    end else if (dec.is_rmw || dec.is_load) begin
      dec.alu_src_a = REG_T;
    end else if (op inside {OP_INX, OP_DEX}) begin
      dec.alu_src_a = REG_X;
    end else if (dec.is_xfer) begin
      dec.alu_src_a = dec.mov_src;
    end else begin
      dec.alu_src_a = REG_A;
    end

    dec.alu_op    = ALU_THA;
    dec.p_src     = P_SRC_ALU;
    dec.flag_mask = `FLAG_N | `FLAG_Z;
    case (op)
      OP_ADC: dec.alu_op = ALU_ADC;
      OP_SBC: dec.alu_op = ALU_SBC;
      OP_AND: dec.alu_op = ALU_AND;
      OP_ORA: dec.alu_op = ALU_ORA;
      OP_EOR: dec.alu_op = ALU_EOR;
      OP_CMP: dec.alu_op = ALU_CMP;
      OP_ASL: dec.alu_op = ALU_ASL;
      OP_LSR: dec.alu_op = ALU_LSR;
      OP_ROL: dec.alu_op = ALU_ROL;
      OP_ROR: dec.alu_op = ALU_ROR;
      OP_INC, OP_INX: dec.alu_op = ALU_INC;
      OP_DEC, OP_DEX: dec.alu_op = ALU_DEC;
      default: ;
    endcase
    if (op inside {OP_ADC, OP_SBC, OP_CMP, OP_ASL, OP_LSR, OP_ROL, OP_ROR}) begin
      dec.flag_mask = `FLAG_N | `FLAG_Z | `FLAG_C;
    end else if (op inside {OP_CLC, OP_SEC}) begin
      dec.flag_mask = `FLAG_C;
      dec.p_src     = (op == OP_SEC) ? P_SRC_SET : P_SRC_CLR;
    end else if (op inside {OP_NOP, OP_STA, OP_STX, OP_STY, OP_JMP}) begin
      dec.flag_mask = '0;
      dec.p_src     = P_SRC_NON;
    end

    // Every opcode lands in a mode the sequencer knows
    assert (dec.mode inside {MODE_IMP, MODE_ACC, MODE_IMM, MODE_ZPG, MODE_ABS});
  end

endmodule

`default_nettype wire

/* hw/timing_sequencer.sv */
`default_nettype none
`include "cpu_ctrl_defs.svh"

module timing_sequencer (
  input  logic                         CLK,
  input  logic                         arst_n,
  input  logic                         rdy,
  input  logic [`DATA_W-1:0]           data_in,
  input  cpu_ctrl_pkg::decoded_instr_t dec,
  output cpu_ctrl_pkg::state_e         state,
  output logic [`DATA_W-1:0]           ir
);

  import cpu_ctrl_pkg::*;

  state_e next_state;

  // Opcode is captured on the edge that leaves T0
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state <= T0_FETCH;
      ir    <= `OPC_NOP;
    end else if (rdy) begin
      state <= next_state;
      if (state == T0_FETCH) begin
        ir <= data_in;
      end
    end
  end

  always_comb begin
    case (state)
      T0_FETCH: next_state = T1_OPER;
      T1_OPER: begin
        case (dec.mode)
          MODE_ZPG: next_state = dec.is_store ? TX_WDATA : TX_RDATA;
          MODE_ABS: next_state = T2_ABS;
          default:  next_state = T0_FETCH;
        endcase
      end
      T2_ABS: begin
        if (dec.op == OP_JMP) begin
          next_state = T0_FETCH;
        end else if (dec.is_store) begin
          next_state = TX_WDATA;
        end else begin
          next_state = TX_RDATA;
        end
      end
      TX_RDATA: next_state = dec.is_rmw ? TX_MDATA : T0_FETCH;
      TX_MDATA: next_state = TX_WDATA;
      default:  next_state = T0_FETCH;
    endcase
  end

  // Stall freezes the whole sequence, opcode included
  a_stall_hold: assert property (@(posedge CLK) disable iff (!arst_n)
    !rdy |=> $stable(state) && $stable(ir));

  // Modify cycle always ends in the write back
  a_mdata_wdata: assert property (@(posedge CLK) disable iff (!arst_n)
    (state == TX_MDATA) && rdy |=> state == TX_WDATA);

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 3
) (
  output logic CLK,
  output logic arst_n
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Release on a falling edge, away from the active edge
  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* test/tb_cpu_ctrl.sv */
`default_nettype none
`include "cpu_ctrl_defs.svh"

module tb_cpu_ctrl;

  import cpu_ctrl_pkg::*;

  // One instruction and what the control word must show for it
  typedef struct {
    logic [7:0] opc;
    int         cycles;
    reg_sel_e   wb;
    alu_op_e    alu;
    int         writes;
    reg_sel_e   st_src;
  } row_t;

  logic               CLK;
  logic               arst_n;
  logic               rdy;
  logic [`DATA_W-1:0] data_in;
  ctrl_word_t         ctrl;
  logic               sync;

  row_t        rows[$];
  logic [15:0] lfsr;
  logic [7:0]  cur_opc;
  int          cyc = 0;
  int          cycle_limit = 1000;
  int          checks;
  int          mismatches;
  int          failures = 0;

  tb_clock_gen #(
    .PERIOD     (4),
    .RST_CYCLES (3)
  ) tb_clock_gen_inst (
    .CLK    (CLK),
    .arst_n (arst_n)
  );

  cpu_ctrl_top cpu_ctrl_top_inst (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .rdy     (rdy),
    .data_in (data_in),
    .ctrl    (ctrl),
    .sync    (sync)
  );

  // Free running cycle count, also the watchdog
  always @(posedge CLK) begin
    cyc <= cyc + 1;
    if (cyc >= cycle_limit) begin
      failures++;
      $display("Timeout: no instruction boundary reached within %0d cycles", cyc);
      $display("Errors: %0d mismatches, %0d other failures in %0d checks",
               mismatches, failures, checks);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_rdy(output logic bit_out);
    lfsr    = lfsr_step(lfsr);
    bit_out = lfsr[0];
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t op=%h %s got %b expected %b", $time, cur_opc, name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t op=%h %s got %h expected %h", $time, cur_opc, name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input reg_sel_e got, input reg_sel_e exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t op=%h %s got %s expected %s",
               $time, cur_opc, name, got.name(), exp.name());
    end
  endtask

  task automatic check_alu(input string name, input alu_op_e got, input alu_op_e exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t op=%h %s got %s expected %s",
               $time, cur_opc, name, got.name(), exp.name());
    end
  endtask

  task automatic check_ctrl(input string name, input ctrl_word_t got, input ctrl_word_t exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t op=%h %s got %h expected %h", $time, cur_opc, name, got, exp);
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      mismatches++;
      $display("MISMATCH t=%0t op=%h %s got %0d expected %0d", $time, cur_opc, name, got, exp);
    end
  endtask

  task automatic add_row(input logic [7:0] opc, input int cycles, input reg_sel_e wb,
                         input alu_op_e alu, input int writes, input reg_sel_e st_src);
    row_t r;
    r.opc    = opc;
    r.cycles = cycles;
    r.wb     = wb;
    r.alu    = alu;
    r.writes = writes;
    r.st_src = st_src;
    rows.push_back(r);
  endtask

  // REG_T as write back means no register is written at T0
  task automatic build_table();
    add_row(`OPC_LDA_IMM, 2, REG_A, ALU_THA, 0, REG_A);
    add_row(`OPC_LDA_ZPG, 3, REG_A, ALU_THA, 0, REG_A);
    add_row(`OPC_LDA_ABS, 4, REG_A, ALU_THA, 0, REG_A);
    add_row(`OPC_LDX_IMM, 2, REG_X, ALU_THA, 0, REG_A);
    add_row(`OPC_LDY_IMM, 2, REG_Y, ALU_THA, 0, REG_A);
    add_row(`OPC_STA_ZPG, 3, REG_T, ALU_THA, 1, REG_A);
    add_row(`OPC_STA_ABS, 4, REG_T, ALU_THA, 1, REG_A);
    add_row(`OPC_STX_ZPG, 3, REG_T, ALU_THA, 1, REG_X);
    add_row(`OPC_STY_ABS, 4, REG_T, ALU_THA, 1, REG_Y);
    add_row(`OPC_ADC_IMM, 2, REG_A, ALU_ADC, 0, REG_A);
    add_row(`OPC_SBC_IMM, 2, REG_A, ALU_SBC, 0, REG_A);
    add_row(`OPC_AND_ZPG, 3, REG_A, ALU_AND, 0, REG_A);
    add_row(`OPC_ORA_IMM, 2, REG_A, ALU_ORA, 0, REG_A);
    add_row(`OPC_EOR_ABS, 4, REG_A, ALU_EOR, 0, REG_A);
    add_row(`OPC_CMP_IMM, 2, REG_T, ALU_CMP, 0, REG_A);
    add_row(`OPC_ASL_ACC, 2, REG_A, ALU_ASL, 0, REG_A);
    add_row(`OPC_LSR_ACC, 2, REG_A, ALU_LSR, 0, REG_A);
    add_row(`OPC_ROL_ZPG, 5, REG_T, ALU_ROL, 2, REG_T);
    add_row(`OPC_ROR_ABS, 6, REG_T, ALU_ROR, 2, REG_T);
    add_row(`OPC_INC_ZPG, 5, REG_T, ALU_INC, 2, REG_T);
    add_row(`OPC_DEC_ABS, 6, REG_T, ALU_DEC, 2, REG_T);
    add_row(`OPC_INX,     2, REG_X, ALU_INC, 0, REG_A);
    add_row(`OPC_DEX,     2, REG_X, ALU_DEC, 0, REG_A);
    add_row(`OPC_TAX,     2, REG_X, ALU_THA, 0, REG_A);
    add_row(`OPC_TAY,     2, REG_Y, ALU_THA, 0, REG_A);
    add_row(`OPC_TXA,     2, REG_A, ALU_THA, 0, REG_A);
    add_row(`OPC_TYA,     2, REG_A, ALU_THA, 0, REG_A);
    add_row(`OPC_CLC,     2, REG_T, ALU_THA, 0, REG_A);
    add_row(`OPC_SEC,     2, REG_T, ALU_THA, 0, REG_A);
    add_row(`OPC_JMP_ABS, 3, REG_T, ALU_THA, 0, REG_A);
    add_row(`OPC_NOP,     2, REG_T, ALU_THA, 0, REG_A);
    // Unused opcode runs as a plain NOP
    add_row(8'h02,        2, REG_T, ALU_THA, 0, REG_A);
  endtask

  task automatic check_reset();
    check_bit("sync", sync, 1'b1);
    check_bit("ctrl.bus.r_w", ctrl.bus.r_w, `RW_READ);
    check_bit("ctrl.regs.a_we", ctrl.regs.a_we, 1'b0);
    check_bit("ctrl.regs.x_we", ctrl.regs.x_we, 1'b0);
    check_bit("ctrl.regs.y_we", ctrl.regs.y_we, 1'b0);
  endtask

  // T0 after the instruction retires it
  task automatic check_writeback(input row_t r);
    alu_op_e exp_alu;
    if (r.writes == 2) begin
      exp_alu = ALU_THA;
    end else begin
      exp_alu = r.alu;
    end
    check_bit("sync", sync, 1'b1);
    check_bit("ctrl.bus.r_w", ctrl.bus.r_w, `RW_READ);
    check_bit("ctrl.regs.a_we", ctrl.regs.a_we, r.wb == REG_A);
    check_bit("ctrl.regs.x_we", ctrl.regs.x_we, r.wb == REG_X);
    check_bit("ctrl.regs.y_we", ctrl.regs.y_we, r.wb == REG_Y);
    check_alu("ctrl.alu.alu_op", ctrl.alu.alu_op, exp_alu);
    if (r.opc == `OPC_CLC || r.opc == `OPC_SEC) begin
      check_byte("ctrl.p.p_mask", ctrl.p.p_mask, `FLAG_C);
    end
  endtask

  // Entered on a falling edge in T0, left on the falling edge of the next T0
  task automatic run_row(input row_t r, input logic stall);
    ctrl_word_t prev_ctrl;
    ctrl_word_t last_ctrl;
    logic       prev_sync;
    logic       step_rdy;
    logic       in_instr;
    logic       done;
    int         stalled;
    int         writes;
    int         start;
    cur_opc   = r.opc;
    data_in   = r.opc;
    stalled   = 0;
    writes    = 0;
    start     = cyc;
    in_instr  = 1'b0;
    done      = 1'b0;
    last_ctrl = ctrl;
    while (!done) begin
      if (stall) begin
        draw_rdy(rdy);
      end else begin
        rdy = 1'b1;
      end
      if (in_instr && rdy) begin
        last_ctrl = ctrl;
        if (ctrl.bus.r_w == `RW_WRITE) begin
          writes++;
          check_reg("ctrl.bus.db_out_src", ctrl.bus.db_out_src, r.st_src);
          // First write of a read-modify-write is the modify cycle
          if (r.writes == 2 && writes == 1) begin
            check_alu("ctrl.alu.alu_op", ctrl.alu.alu_op, r.alu);
          end
        end
      end
      prev_ctrl = ctrl;
      prev_sync = sync;
      step_rdy  = rdy;
      if (!rdy) begin
        stalled++;
      end
      @(negedge CLK);
      if (!step_rdy) begin
        check_ctrl("ctrl", ctrl, prev_ctrl);
        check_bit("sync", sync, prev_sync);
      end else if (!in_instr) begin
        in_instr = 1'b1;
      end else if (sync) begin
        done = 1'b1;
      end
    end
    check_cycles("elapsed cycles", cyc - start, r.cycles + stalled);
    check_cycles("write cycles", writes, r.writes);
    if (r.opc == `OPC_JMP_ABS) begin
      check_bit("ctrl.pc.pcl_we", last_ctrl.pc.pcl_we, 1'b1);
      check_bit("ctrl.pc.pch_we", last_ctrl.pc.pch_we, 1'b1);
      check_bit("ctrl.pc.pcl_src is T", last_ctrl.pc.pcl_src == PCL_SRC_T, 1'b1);
      check_bit("ctrl.pc.pch_src is MEM", last_ctrl.pc.pch_src == PCH_SRC_MEM, 1'b1);
    end
    check_writeback(r);
  endtask

  initial begin
    rdy        = 1'b0;
    data_in    = `OPC_NOP;
    lfsr       = 16'd65345;
    cur_opc    = `OPC_NOP;
    checks     = 0;
    mismatches = 0;
    build_table();
    // Worst case 6 cycles per row, doubled for the stalled pass
    cycle_limit = rows.size() * 6 * 2 + rows.size() * 6 + 50;

    wait (arst_n === 1'b1);
    @(negedge CLK);
    check_reset();

    foreach (rows[i]) begin
      run_row(rows[i], 1'b0);
    end
    foreach (rows[i]) begin
      run_row(rows[i], 1'b1);
    end

    $display("Errors: %0d mismatches, %0d other failures in %0d checks",
             mismatches, failures, checks);
    if (mismatches == 0 && failures == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/cpu_ctrl_pkg.sv
hw/opcode_decoder.sv
hw/timing_sequencer.sv
hw/control_word_gen.sv
hw/cpu_ctrl_top.sv
test/tb_clock_gen.sv
test/tb_cpu_ctrl.sv
